//--- project.f
source/cache_pkg.sv
source/cache_arrays.sv
source/way_match.sv
source/victim_select.sv
source/cache_ctrl.sv
source/l1d_cache.sv
test/tb_clock.sv
test/mem_model.sv
test/tb_l1d_cache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_l1d_cache
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_l1d_cache.sv
`timescale 1ns/1ps

module tb_l1d_cache
    import cache_pkg::*;
();

    localparam logic [DATA_W-1:0] FILL_XOR   = 32'h3C5A_0000;
    localparam int                NUM_BLOCKS = 2 ** (ADDR_W - OFFSET_W);
    // Nine accesses of at most about 30 cycles each, with a wide margin
    localparam int                MAX_CYCLES = 2000;
    localparam logic [ADDR_W-1:0] ADDR_A     = {9'h0A1, 3'd5, 2'd1, 2'b00};

    logic               clk;
    logic               rstn;
    cpu_req_t           req;
    logic               req_valid;
    logic               req_ready;
    logic [DATA_W-1:0]  resp_data;
    logic               resp_valid;
    logic               resp_ready;
    mem_req_t           mem_req;
    logic               mem_req_valid;
    logic               mem_req_ready;
    logic [BLOCK_W-1:0] mem_rsp_block;
    logic               mem_rsp_valid;
    logic               mem_rsp_ready;

    logic               hit_expected;
    logic [DATA_W-1:0]  exp_data;
    logic [BLOCK_W-1:0] ref_blocks [NUM_BLOCKS];
    logic               wb_first_seen = 1'b0;
    int                 errors = 0;
    int                 cycles = 0;
    logic               hit_read_accept;
    logic               hit_write_accept;
    logic               wb_accept;

    tb_clock u_clock (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    mem_model #(.FILL_XOR(FILL_XOR)) u_mem (
        .clk_i           (clk),
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_rsp_block_o (mem_rsp_block),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_ready_i (mem_rsp_ready)
    );

    l1d_cache uut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .resp_data_o     (resp_data),
        .resp_valid_o    (resp_valid),
        .resp_ready_i    (resp_ready),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_block_i (mem_rsp_block),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready)
    );

    assign hit_read_accept  = hit_expected && req_valid && req_ready && !req.we;
    assign hit_write_accept = hit_expected && req_valid && req_ready && req.we;
    assign wb_accept        = mem_req_valid && mem_req_ready && mem_req.we;

    a_reset_outputs: assert property (
        @(posedge clk) $rose(rstn) |-> req_ready && !resp_valid && !mem_req_valid
    ) else begin
        errors++;
        $display("FAILED reset outputs: req_ready_o=%h resp_valid_o=%h mem_req_valid_o=%h",
                 $sampled(req_ready), $sampled(resp_valid), $sampled(mem_req_valid));
    end

    a_reset_rsp_ready: assert property (
        @(posedge clk) $rose(rstn) |-> !mem_rsp_ready
    ) else begin
        errors++;
        $display("FAILED mem_rsp_ready_o: expected 0, got %h", $sampled(mem_rsp_ready));
    end

    a_hit_read_gap: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(hit_read_accept) |-> !resp_valid
    ) else begin
        errors++;
        $display("FAILED resp_valid_o: expected 0, got %h", $sampled(resp_valid));
    end

    a_hit_read_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(hit_read_accept, 2) |-> resp_valid
    ) else begin
        errors++;
        $display("FAILED resp_valid_o: expected 1, got %h", $sampled(resp_valid));
    end

    a_hit_write_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(hit_write_accept, 2) |-> req_ready
    ) else begin
        errors++;
        $display("FAILED req_ready_o: expected 1, got %h", $sampled(req_ready));
    end

    a_resp_data: assert property (
        @(posedge clk) disable iff (!rstn)
        resp_valid |-> resp_data == exp_data
    ) else begin
        errors++;
        $display("FAILED resp_data_o: expected %h, got %h", exp_data, $sampled(resp_data));
    end

    a_resp_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        $past(resp_valid && !resp_ready) |-> resp_valid
    ) else begin
        errors++;
        $display("FAILED resp_valid_o: expected 1, got %h", $sampled(resp_valid));
    end

    a_busy_while_resp: assert property (
        @(posedge clk) disable iff (!rstn)
        resp_valid |-> !req_ready
    ) else begin
        errors++;
        $display("FAILED req_ready_o: expected 0, got %h", $sampled(req_ready));
    end

    a_wb_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        wb_accept |-> mem_req.addr.f.offset == '0
    ) else begin
        errors++;
        $display("FAILED mem_req_o.addr: expected offset 0, got %h", $sampled(mem_req.addr.flat));
    end

    // Evicted block must match every write made to it so far
    a_wb_block: assert property (
        @(posedge clk) disable iff (!rstn)
        wb_accept |-> mem_req.block == ref_blocks[mem_req.addr.flat[ADDR_W-1:OFFSET_W]]
    ) else begin
        errors++;
        $display("FAILED mem_req_o.block: expected %h, got %h",
                 ref_blocks[$sampled(mem_req.addr.flat[ADDR_W-1:OFFSET_W])],
                 $sampled(mem_req.block));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (wb_accept && mem_req.addr.flat[ADDR_W-1:OFFSET_W] == ADDR_A[ADDR_W-1:OFFSET_W]) begin
            wb_first_seen <= 1'b1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [BLOCK_W-1:0] blk;
        blk = ref_blocks[addr[ADDR_W-1:OFFSET_W]];
        return blk[addr[OFFSET_W-1 -: WORD_SEL_W] * DATA_W +: DATA_W];
    endfunction

    // One request, then wait for its response or for the cache to go idle
    task automatic access(
        input logic [ADDR_W-1:0] addr,
        input logic              we,
        input logic [DATA_W-1:0] wdata,
        input logic              hit,
        input int                hold
    );
        logic accepted;
        accepted      = 1'b0;
        req.addr.flat = addr;
        req.we        = we;
        req.wdata     = wdata;
        req_valid     = 1'b1;
        hit_expected  = hit;
        if (we) begin
            ref_blocks[addr[ADDR_W-1:OFFSET_W]][addr[OFFSET_W-1 -: WORD_SEL_W] * DATA_W +: DATA_W]
                = wdata;
        end else begin
            exp_data = expected_word(addr);
        end
        while (!accepted) begin
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid    = 1'b0;
        hit_expected = 1'b0;
        if (!we) begin
            while (!resp_valid) begin
                @(posedge clk);
                #1;
            end
            repeat (hold) begin
                @(posedge clk);
                #1;
            end
            resp_ready = 1'b1;
            @(posedge clk);
            #1;
            resp_ready = 1'b0;
        end else begin
            while (!req_ready) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        req          = '0;
        req_valid    = 1'b0;
        resp_ready   = 1'b0;
        hit_expected = 1'b0;
        exp_data     = '0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int w = 0; w < BLOCK_W / DATA_W; w++) begin
                ref_blocks[b][w*DATA_W +: DATA_W] = DATA_W'(b * 4 + w) ^ FILL_XOR;
            end
        end
        @(posedge rstn);
        @(posedge clk);
        #1;

        // Read miss, then a hit on another word of the same block
        access({9'h011, 3'd2, 2'd0, 2'b00}, 1'b0, '0, 1'b0, 0);
        access({9'h011, 3'd2, 2'd3, 2'b00}, 1'b0, '0, 1'b1, 0);

        access({9'h011, 3'd2, 2'd1, 2'b00}, 1'b1, 32'hCAFE_0001, 1'b1, 0);
        access({9'h011, 3'd2, 2'd1, 2'b00}, 1'b0, '0, 1'b1, 0);

        // Response held back for five cycles
        access({9'h022, 3'd6, 2'd2, 2'b00}, 1'b0, '0, 1'b0, 5);

        // Four fills so far leave the round-robin pointer on way 0, so C evicts A
        access(ADDR_A, 1'b1, 32'h1111_A001, 1'b0, 0);
        access({9'h0B2, 3'd5, 2'd2, 2'b00}, 1'b1, 32'h2222_B002, 1'b0, 0);
        access({9'h0C3, 3'd5, 2'd3, 2'b00}, 1'b1, 32'h3333_C003, 1'b0, 0);
        access(ADDR_A, 1'b0, '0, 1'b0, 0);

        repeat (2) @(posedge clk);
        if (!wb_first_seen) begin
            errors++;
            $display("no write-back of the first written block reached memory");
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/mem_model.sv
`timescale 1ns/1ps

module mem_model
    import cache_pkg::*;
#(
    parameter logic [DATA_W-1:0] FILL_XOR = '0
) (
    input  logic               clk_i,
    input  mem_req_t           mem_req_i,
    input  logic               mem_req_valid_i,
    output logic               mem_req_ready_o,
    output logic [BLOCK_W-1:0] mem_rsp_block_o,
    output logic               mem_rsp_valid_o,
    input  logic               mem_rsp_ready_i
);

    localparam int NUM_BLOCKS = 2 ** (ADDR_W - OFFSET_W);

    logic [BLOCK_W-1:0] blocks [NUM_BLOCKS];
    logic [7:0]         lfsr_q;

    // Taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Two bits per delay, giving 0 to 3 cycles
    task automatic draw_delay(output int d);
        d = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            d = (d << 1) | int'(lfsr_q[0]);
        end
    endtask

    initial begin
        int                         delay;
        logic [ADDR_W-OFFSET_W-1:0] blk;
        logic                       wr_req;
        logic [BLOCK_W-1:0]         wr_block;
        logic                       taken;
        lfsr_q = 8'd28;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int w = 0; w < BLOCK_W / DATA_W; w++) begin
                blocks[b][w*DATA_W +: DATA_W] = DATA_W'(b * 4 + w) ^ FILL_XOR;
            end
        end
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_block_o = '0;
        @(posedge clk_i);
        #1;
        forever begin
            if (!mem_req_valid_i) begin
                @(posedge clk_i);
                #1;
            end else begin
                draw_delay(delay);
                repeat (delay) begin
                    @(posedge clk_i);
                    #1;
                end
                blk      = mem_req_i.addr.flat[ADDR_W-1:OFFSET_W];
                wr_req   = mem_req_i.we;
                wr_block = mem_req_i.block;
                mem_req_ready_o = 1'b1;
                @(posedge clk_i);
                #1;
                mem_req_ready_o = 1'b0;
                if (wr_req) begin
                    blocks[blk] = wr_block;
                end else begin
                    draw_delay(delay);
                    repeat (delay) begin
                        @(posedge clk_i);
                        #1;
                    end
                    mem_rsp_block_o = blocks[blk];
                    mem_rsp_valid_o = 1'b1;
                    taken = 1'b0;
                    while (!taken) begin
                        taken = mem_rsp_ready_i;
                        @(posedge clk_i);
                        #1;
                    end
                    mem_rsp_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held low over three rising edges
    initial begin
        rstn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1;
        rstn_o = 1'b1;
    end

endmodule

//--- source/l1d_cache.sv
`timescale 1ns/1ps

module l1d_cache
    import cache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstn_i,

    input  cpu_req_t           req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,

    output logic [DATA_W-1:0]  resp_data_o,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,

    output mem_req_t           mem_req_o,
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    input  logic [BLOCK_W-1:0] mem_rsp_block_i,
    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o
);

    set_view_t          set_view;
    set_blocks_t        set_blocks;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;
    logic               victim_dirty;
    logic               advance;

    logic               wr_en;
    logic [WAY_W-1:0]   wr_way;
    logic [TAG_W-1:0]   wr_tag;
    logic [BLOCK_W-1:0] wr_block;
    logic               wr_valid;
    logic               wr_dirty;

    cache_arrays u_arrays (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rd_index_i (index),
        .wr_en_i    (wr_en),
        .wr_way_i   (wr_way),
        .wr_tag_i   (wr_tag),
        .wr_block_i (wr_block),
        .wr_valid_i (wr_valid),
        .wr_dirty_i (wr_dirty),
        .set_o      (set_view),
        .blocks_o   (set_blocks)
    );

    way_match u_match (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .set_i     (set_view),
        .tag_i     (tag),
        .hit_o     (hit),
        .hit_way_o (hit_way)
    );

    victim_select u_victim (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .set_i          (set_view),
        .advance_i      (advance),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    cache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .resp_data_o     (resp_data_o),
        .resp_valid_o    (resp_valid_o),
        .resp_ready_i    (resp_ready_i),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .victim_way_i    (victim_way),
        .victim_dirty_i  (victim_dirty),
        .set_i           (set_view),
        .blocks_i        (set_blocks),
        .index_o         (index),
        .tag_o           (tag),
        .wr_en_o         (wr_en),
        .wr_way_o        (wr_way),
        .wr_tag_o        (wr_tag),
        .wr_block_o      (wr_block),
        .wr_valid_o      (wr_valid),
        .wr_dirty_o      (wr_dirty),
        .advance_o       (advance),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_block_i (mem_rsp_block_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstn_i,

    input  cpu_req_t           req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,

    output logic [DATA_W-1:0]  resp_data_o,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,

    input  logic               hit_i,
    input  logic [WAY_W-1:0]   hit_way_i,
    input  logic [WAY_W-1:0]   victim_way_i,
    input  logic               victim_dirty_i,
    input  set_view_t          set_i,
    input  set_blocks_t        blocks_i,
    output logic [INDEX_W-1:0] index_o,
    output logic [TAG_W-1:0]   tag_o,

    output logic               wr_en_o,
    output logic [WAY_W-1:0]   wr_way_o,
    output logic [TAG_W-1:0]   wr_tag_o,
    output logic [BLOCK_W-1:0] wr_block_o,
    output logic               wr_valid_o,
    output logic               wr_dirty_o,
    output logic               advance_o,

    output mem_req_t           mem_req_o,
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    input  logic [BLOCK_W-1:0] mem_rsp_block_i,
    input  logic               mem_rsp_valid_i,
    output logic               mem_rsp_ready_o
);

    ctrl_state_t             state_q;
    ctrl_state_t             state_d;
    cpu_req_t                req_q;
    logic [WAY_W-1:0]        way_q;
    logic [DATA_W-1:0]       resp_data_q;
    logic [WORD_SEL_W-1:0]   word_sel;
    logic [BLOCK_W-1:0]      hit_block;
    logic [BLOCK_W-1:0]      merged_block;
    logic [DATA_W-1:0]       hit_word;
    logic [TAG_W-1:0]        mem_tag;

    assign index_o  = req_q.addr.f.index;
    assign tag_o    = req_q.addr.f.tag;
    assign word_sel = req_q.addr.f.offset[OFFSET_W-1 -: WORD_SEL_W];

    assign req_ready_o     = (state_q == IDLE);
    assign resp_valid_o    = (state_q == RESPOND);
    assign resp_data_o     = resp_data_q;
    assign mem_req_valid_o = (state_q == WRITEBACK) || (state_q == FILL_REQ);
    assign mem_rsp_ready_o = (state_q == FILL_WAIT);
    assign advance_o       = (state_q == FILL_WAIT) && mem_rsp_valid_i;

    always_comb begin
        hit_block    = blocks_i[hit_way_i];
        hit_word     = hit_block[word_sel * DATA_W +: DATA_W];
        merged_block = hit_block;
        merged_block[word_sel * DATA_W +: DATA_W] = req_q.wdata;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = req_q.we ? IDLE : RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            RESPOND: begin
                if (resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            WRITEBACK: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                // Back to LOOKUP, which now serves the request as a hit
                if (mem_rsp_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Victim block goes out first, then the read of the requested block
    always_comb begin
        mem_tag   = (state_q == WRITEBACK) ? set_i.tag[way_q] : req_q.addr.f.tag;
        mem_req_o = '0;
        mem_req_o.addr.flat = {mem_tag, req_q.addr.f.index, OFFSET_W'(0)};
        if (state_q == WRITEBACK) begin
            mem_req_o.we    = 1'b1;
            mem_req_o.block = blocks_i[way_q];
        end
    end

    always_comb begin
        wr_en_o    = (state_q == LOOKUP) && hit_i && req_q.we;
        wr_way_o   = hit_way_i;
        wr_tag_o   = req_q.addr.f.tag;
        wr_block_o = merged_block;
        wr_valid_o = 1'b1;
        wr_dirty_o = 1'b1;
        if (state_q == FILL_WAIT) begin
            wr_en_o    = mem_rsp_valid_i;
            wr_way_o   = way_q;
            wr_block_o = mem_rsp_block_i;
            wr_dirty_o = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && req_valid_i) begin
                req_q <= req_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP && hit_i) begin
            resp_data_q <= hit_word;
        end
        if (state_q == LOOKUP && !hit_i) begin
            way_q <= victim_way_i;
        end
    end

    a_mem_req_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
    );

endmodule

//--- source/victim_select.sv
`timescale 1ns/1ps

module victim_select
    import cache_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  set_view_t        set_i,
    input  logic             advance_i,
    output logic [WAY_W-1:0] victim_way_o,
    output logic             victim_dirty_o
);

    logic [WAY_W-1:0] rr_ptr_q;
    logic             free_found;

    // First invalid way, otherwise the round-robin pointer
    always_comb begin
        victim_way_o = rr_ptr_q;
        free_found   = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!free_found && !set_i.valid[w]) begin
                victim_way_o = WAY_W'(w);
                free_found   = 1'b1;
            end
        end
    end

    assign victim_dirty_o = set_i.valid[victim_way_o] && set_i.dirty[victim_way_o];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_ptr_q <= '0;
        end else if (advance_i) begin
            if (rr_ptr_q == WAY_W'(NUM_WAYS - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= rr_ptr_q + 1'b1;
            end
        end
    end

endmodule

//--- source/way_match.sv
`timescale 1ns/1ps

module way_match
    import cache_pkg::*;
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  set_view_t        set_i,
    input  logic [TAG_W-1:0] tag_i,
    output logic             hit_o,
    output logic [WAY_W-1:0] hit_way_o
);

    logic [NUM_WAYS-1:0] match;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = set_i.valid[w] && (set_i.tag[w] == tag_i);
        end
    end

    // Encode the matching way, lowest index wins
    always_comb begin
        hit_way_o = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_o = |match;

    // A block is only ever filled on a miss, so a tag lives in one way of its set
    a_single_match: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(match)
    );

endmodule

//--- source/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays
    import cache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  logic               wr_en_i,
    input  logic [WAY_W-1:0]   wr_way_i,
    input  logic [TAG_W-1:0]   wr_tag_i,
    input  logic [BLOCK_W-1:0] wr_block_i,
    input  logic               wr_valid_i,
    input  logic               wr_dirty_i,
    output set_view_t          set_o,
    output set_blocks_t        blocks_o
);

    logic [NUM_WAYS-1:0][TAG_W-1:0] tag_mem   [NUM_SETS];
    set_blocks_t                    block_mem [NUM_SETS];
    logic [NUM_WAYS-1:0]            valid_q   [NUM_SETS];
    logic [NUM_WAYS-1:0]            dirty_q   [NUM_SETS];

    // Read side is the set of the current request
    assign set_o.tag   = tag_mem[rd_index_i];
    assign set_o.valid = valid_q[rd_index_i];
    assign set_o.dirty = dirty_q[rd_index_i];
    assign blocks_o    = block_mem[rd_index_i];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[rd_index_i][wr_way_i]   <= wr_tag_i;
            block_mem[rd_index_i][wr_way_i] <= wr_block_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[rd_index_i][wr_way_i] <= wr_valid_i;
            dirty_q[rd_index_i][wr_way_i] <= wr_dirty_i;
        end
    end

    a_wr_way_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wr_en_i |-> !$isunknown(wr_way_i)
    );

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 8;

    localparam int OFFSET_W   = 4;
    localparam int INDEX_W    = 3;
    localparam int TAG_W      = 9;
    localparam int WAY_W      = 1;
    localparam int WORD_SEL_W = 2;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Flat word on the memory bus, split into fields for lookup
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        addr_fields_t      f;
    } addr_t;

    typedef struct packed {
        addr_t             addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        addr_t              addr;
        logic               we;
        logic [BLOCK_W-1:0] block;
    } mem_req_t;

    typedef struct packed {
        logic [NUM_WAYS-1:0][TAG_W-1:0] tag;
        logic [NUM_WAYS-1:0]            valid;
        logic [NUM_WAYS-1:0]            dirty;
    } set_view_t;

    typedef logic [NUM_WAYS-1:0][BLOCK_W-1:0] set_blocks_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT
    } ctrl_state_t;

endpackage
